//--- dram_params.svh
`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

// One DRAM word as seen on the controller local side
`define DRAM_WIDTH 128
`define DRAM_BYTES_LOG2 4

// Instruction line is a single DRAM word
`define ILINE_WORDS 1

// Data line spans two DRAM words
`define DLINE_WORDS 2
`define DLINE_BYTES_LOG2 5

// Extra data lines fetched when no stride is given
`define DEFAULT_DPREFETCHES 1

// Mask on stride times length, 255 bytes is 16 words
`define PREFETCH_BYTE_CAP 255

// Stride field sits at dbus_prefetch[16 +: STRIDE_BITS]
`define STRIDE_BITS 6

`endif

//--- mem_hier_pkg.sv
`include "dram_params.svh"

package mem_hier_pkg;

  // Byte address on both CPU buses
  typedef logic [31:0] addr_t;

  // Word as returned by the DDR controller
  typedef logic [`DRAM_WIDTH-1:0] dram_word_t;

  // Cache line widths
  typedef logic [`DRAM_WIDTH*`ILINE_WORDS-1:0] iline_t;
  typedef logic [`DRAM_WIDTH*`DLINE_WORDS-1:0] dline_t;

  // Index of the last DRAM word in a burst
  typedef logic [15:0] blocks_t;

endpackage

//--- request_decode.sv
`timescale 1ns/1ns
`include "dram_params.svh"

module request_decode
  import mem_hier_pkg::*;
(
  input  logic        clk133,
  input  logic        rst_n,
  input  logic        ibus_en,
  input  addr_t       ibus_address,
  input  logic        dbus_en,
  input  addr_t       dbus_address,
  input  logic [31:0] dbus_prefetch,
  input  logic        local_init_done,
  input  logic        done,
  output logic        ibus_wait,
  output logic        dbus_wait,
  output logic        start,
  output addr_t       start_addr,
  output blocks_t     start_blocks,
  output logic        start_is_data
);

  localparam int ILINE_LOG2 = `DRAM_BYTES_LOG2 + $clog2(`ILINE_WORDS);
  localparam addr_t ILINE_MASK = ~addr_t'((1 << ILINE_LOG2) - 1);
  localparam addr_t DLINE_MASK = ~addr_t'((1 << `DLINE_BYTES_LOG2) - 1);
  localparam int PF_TOP = 16 + `STRIDE_BITS;
  localparam blocks_t DFLT_BLOCKS = blocks_t'(`DLINE_WORDS * (1 + `DEFAULT_DPREFETCHES) - 1);

  logic                      ibus_hold;
  logic                      dbus_hold;
  logic                      ibus_elig;
  logic                      dbus_elig;
  logic                      busy;
  logic                      take;
  logic                      pick_data;
  logic [`STRIDE_BITS-1:0]   stride;
  logic                      stride_ok;
  logic [`STRIDE_BITS+15:0]  pf_product;
  logic [15:0]               pf_bytes;
  blocks_t                   pf_blocks;
  blocks_t                   data_blocks;

  // A bus stays out of arbitration until it drops en after service
  assign ibus_elig = ibus_en && !ibus_hold;
  assign dbus_elig = dbus_en && !dbus_hold;
  assign busy = ibus_wait || dbus_wait;
  assign take = !busy && local_init_done && (ibus_elig || dbus_elig);

  // Round robin against the last grant on contention
  assign pick_data = dbus_elig && (!ibus_elig || !start_is_data);

  // Prefetch field is {stride, length}
  assign stride = dbus_prefetch[16 +: `STRIDE_BITS];
  assign stride_ok = (|stride) && (dbus_prefetch[31:PF_TOP] == '0);
  assign pf_product = stride * dbus_prefetch[15:0];
  assign pf_bytes = pf_product[15:0] & 16'(`PREFETCH_BYTE_CAP);

  // Pad the word count out to a whole data line
  assign pf_blocks = blocks_t'(pf_bytes >> `DRAM_BYTES_LOG2) |
                     blocks_t'(`DLINE_WORDS - 1);
  assign data_blocks = stride_ok ? pf_blocks : DFLT_BLOCKS;

  always_ff @(posedge clk133 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start         <= 1'b0;
      ibus_wait     <= 1'b0;
      dbus_wait     <= 1'b0;
      start_is_data <= 1'b0;
      ibus_hold     <= 1'b0;
      dbus_hold     <= 1'b0;
    end
    else
    begin
      start <= take;
      // start_is_data also serves as the round robin pointer
      if (take)
      begin
        start_is_data <= pick_data;
        ibus_wait     <= !pick_data;
        dbus_wait     <= pick_data;
      end
      else if (done)
      begin
        ibus_wait <= 1'b0;
        dbus_wait <= 1'b0;
      end
      if (done && ibus_wait)
        ibus_hold <= 1'b1;
      else if (!ibus_en)
        ibus_hold <= 1'b0;
      if (done && dbus_wait)
        dbus_hold <= 1'b1;
      else if (!dbus_en)
        dbus_hold <= 1'b0;
    end
  end

  // Request payload for the sequencer
  always_ff @(posedge clk133)
  begin
    if (take)
    begin
      start_addr   <= pick_data ? (dbus_address & DLINE_MASK) : (ibus_address & ILINE_MASK);
      start_blocks <= pick_data ? data_blocks : blocks_t'(`ILINE_WORDS - 1);
    end
  end

endmodule

//--- dram_sequencer.sv
`timescale 1ns/1ns
`include "dram_params.svh"

module dram_sequencer
  import mem_hier_pkg::*;
(
  input  logic       clk133,
  input  logic       rst_n,
  input  logic       start,
  input  addr_t      start_addr,
  input  blocks_t    start_blocks,
  input  logic       start_is_data,
  input  logic       local_ready,
  input  dram_word_t local_rdata,
  input  logic       local_rdata_valid,
  output logic       local_read_req,
  output addr_t      local_address,
  output logic       done,
  output logic       iword_valid,
  output logic       dword_valid,
  output dram_word_t word
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BURST,
    S_FINISH
  } state_t;

  state_t      state;
  addr_t       addr_r;
  blocks_t     blocks_r;
  logic        is_data_r;
  logic [16:0] issue_cnt;
  logic [16:0] rx_cnt;
  logic [16:0] burst_len;
  logic        accept;
  logic        rx;
  logic        last_rx;

  // A burst is blocks plus one words
  assign burst_len = {1'b0, blocks_r} + 17'd1;

  // Keep requesting until every word of the burst has been accepted
  assign local_read_req = (state == S_BURST) && (issue_cnt != burst_len);
  assign accept = local_read_req && local_ready;

  // Controller takes word addresses
  assign local_address = addr_r >> `DRAM_BYTES_LOG2;

  assign rx = local_rdata_valid && (state == S_BURST);
  assign last_rx = rx && (rx_cnt == {1'b0, blocks_r});

  // Finish lasts one cycle, which makes done a single pulse
  assign done = (state == S_FINISH);

  always_ff @(posedge clk133 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      issue_cnt <= '0;
      rx_cnt    <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          issue_cnt <= '0;
          rx_cnt    <= '0;
          if (start)
            state <= S_BURST;
        end
        S_BURST:
        begin
          // Issue and receive run side by side
          if (accept)
            issue_cnt <= issue_cnt + 17'd1;
          if (rx)
            rx_cnt <= rx_cnt + 17'd1;
          if (last_rx)
            state <= S_FINISH;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Burst parameters and the running request address
  always_ff @(posedge clk133)
  begin
    if (start && (state == S_IDLE))
    begin
      addr_r    <= start_addr;
      blocks_r  <= start_blocks;
      is_data_r <= start_is_data;
    end
    else if (accept)
      addr_r <= addr_r + addr_t'(1 << `DRAM_BYTES_LOG2);
  end

  // Steer each returned word to the side that asked for it
  always_ff @(posedge clk133 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      iword_valid <= 1'b0;
      dword_valid <= 1'b0;
    end
    else
    begin
      iword_valid <= rx && !is_data_r;
      dword_valid <= rx && is_data_r;
    end
  end

  always_ff @(posedge clk133)
  begin
    if (local_rdata_valid)
      word <= local_rdata;
  end

endmodule

//--- fill_assembler.sv
`timescale 1ns/1ns

module fill_assembler
  import mem_hier_pkg::*;
#(
  parameter type line_t = dline_t
)
(
  input  logic       clk133,
  input  logic       rst_n,
  input  logic       start,
  input  addr_t      start_addr,
  input  logic       word_valid,
  input  dram_word_t word,
  output addr_t      filladdr,
  output line_t      filldata,
  output logic       fillwe
);

  localparam int LINE_BITS = $bits(line_t);
  localparam int WORD_BITS = $bits(dram_word_t);
  localparam int WORDS = LINE_BITS / WORD_BITS;
  localparam int LINE_BYTES = LINE_BITS / 8;

  line_t            line_r;
  line_t            shifted;
  logic [WORDS-1:0] slot_r;
  addr_t            addr_r;

  // New word enters at the top, so the first word ends up lowest
  assign shifted = (line_t'(word) << (LINE_BITS - WORD_BITS)) | (line_r >> WORD_BITS);

  // Line is complete when the last slot receives its word
  assign fillwe = word_valid && slot_r[WORDS-1];
  assign filldata = shifted;
  assign filladdr = addr_r;

  // One-hot slot of the next expected word
  always_ff @(posedge clk133 or negedge rst_n)
  begin
    if (!rst_n)
      slot_r <= WORDS'(1);
    else if (start)
      slot_r <= WORDS'(1);
    else if (word_valid)
      slot_r <= (slot_r << 1) | (slot_r >> (WORDS - 1));
  end

  always_ff @(posedge clk133)
  begin
    if (word_valid)
      line_r <= shifted;
  end

  // Line address steps by one line per fill
  always_ff @(posedge clk133)
  begin
    if (start)
      addr_r <= start_addr;
    else if (fillwe)
      addr_r <= addr_r + addr_t'(LINE_BYTES);
  end

endmodule

//--- mem_hierarchy.sv
`timescale 1ns/1ns

module mem_hierarchy
  import mem_hier_pkg::*;
(
  input  logic        clk133,
  input  logic        rst_n,
  input  logic        ibus_en,
  input  addr_t       ibus_address,
  input  logic        dbus_en,
  input  addr_t       dbus_address,
  input  logic [31:0] dbus_prefetch,
  input  logic        local_ready,
  input  logic        local_init_done,
  input  dram_word_t  local_rdata,
  input  logic        local_rdata_valid,
  output logic        ibus_wait,
  output logic        dbus_wait,
  output logic        local_read_req,
  output addr_t       local_address,
  output addr_t       imem_filladdr,
  output iline_t      imem_filldata,
  output logic        imem_fillwe,
  output addr_t       dmem_filladdr,
  output dline_t      dmem_filldata,
  output logic        dmem_fillwe
);

  logic       start;
  addr_t      start_addr;
  blocks_t    start_blocks;
  logic       start_is_data;
  logic       done;
  logic       iword_valid;
  logic       dword_valid;
  dram_word_t word;

  // Arbitration and burst sizing
  request_decode u_decode (
    .clk133          (clk133),
    .rst_n           (rst_n),
    .ibus_en         (ibus_en),
    .ibus_address    (ibus_address),
    .dbus_en         (dbus_en),
    .dbus_address    (dbus_address),
    .dbus_prefetch   (dbus_prefetch),
    .local_init_done (local_init_done),
    .done            (done),
    .ibus_wait       (ibus_wait),
    .dbus_wait       (dbus_wait),
    .start           (start),
    .start_addr      (start_addr),
    .start_blocks    (start_blocks),
    .start_is_data   (start_is_data)
  );

  // Controller read bursts
  dram_sequencer u_seq (
    .clk133            (clk133),
    .rst_n             (rst_n),
    .start             (start),
    .start_addr        (start_addr),
    .start_blocks      (start_blocks),
    .start_is_data     (start_is_data),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .local_read_req    (local_read_req),
    .local_address     (local_address),
    .done              (done),
    .iword_valid       (iword_valid),
    .dword_valid       (dword_valid),
    .word              (word)
  );

  fill_assembler #(.line_t(iline_t)) u_ifill (
    .clk133     (clk133),
    .rst_n      (rst_n),
    .start      (start),
    .start_addr (start_addr),
    .word_valid (iword_valid),
    .word       (word),
    .filladdr   (imem_filladdr),
    .filldata   (imem_filldata),
    .fillwe     (imem_fillwe)
  );

  fill_assembler #(.line_t(dline_t)) u_dfill (
    .clk133     (clk133),
    .rst_n      (rst_n),
    .start      (start),
    .start_addr (start_addr),
    .word_valid (dword_valid),
    .word       (word),
    .filladdr   (dmem_filladdr),
    .filldata   (dmem_filldata),
    .fillwe     (dmem_fillwe)
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk133,
  output logic rst_n
);

  // 20 ns period
  initial
  begin
    clk133 = 1'b0;
    forever #10 clk133 = ~clk133;
  end

  // Reset held for 10 cycles
  initial
  begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk133);
    rst_n <= 1'b1;
  end

endmodule

//--- tb_mem_hierarchy.sv
`timescale 1ns/1ns
`include "dram_params.svh"

module tb_mem_hierarchy
  import mem_hier_pkg::*;
();

  localparam int NUM_TESTS = 8;

  logic        clk133;
  logic        rst_n;
  logic        ibus_en;
  addr_t       ibus_address;
  logic        dbus_en;
  addr_t       dbus_address;
  logic [31:0] dbus_prefetch;
  logic        local_ready;
  logic        local_init_done;
  dram_word_t  local_rdata;
  logic        local_rdata_valid;
  logic        ibus_wait;
  logic        dbus_wait;
  logic        local_read_req;
  addr_t       local_address;
  addr_t       imem_filladdr;
  iline_t      imem_filldata;
  logic        imem_fillwe;
  addr_t       dmem_filladdr;
  dline_t      dmem_filldata;
  logic        dmem_fillwe;

  // Stimulus table, source 0 is ibus, 1 is dbus, 2 is both at once
  string       t_name  [NUM_TESTS];
  int          t_src   [NUM_TESTS];
  addr_t       t_addr  [NUM_TESTS];
  logic [31:0] t_pf    [NUM_TESTS];
  int          t_lines [NUM_TESTS];
  int          t_count = 0;

  logic [31:0] lfsr = 32'hc6a4_edf6;
  int          cycle = 0;
  int          init_cnt = 0;
  addr_t       pend_addr [$];
  int          pend_due [$];
  addr_t       ifill_addr [$];
  iline_t      ifill_data [$];
  addr_t       dfill_addr [$];
  dline_t      dfill_data [$];
  logic        last_data = 1'b0;

  tb_clock_gen u_clk (
    .clk133 (clk133),
    .rst_n  (rst_n)
  );

  mem_hierarchy UUT (
    .clk133            (clk133),
    .rst_n             (rst_n),
    .ibus_en           (ibus_en),
    .ibus_address      (ibus_address),
    .dbus_en           (dbus_en),
    .dbus_address      (dbus_address),
    .dbus_prefetch     (dbus_prefetch),
    .local_ready       (local_ready),
    .local_init_done   (local_init_done),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .ibus_wait         (ibus_wait),
    .dbus_wait         (dbus_wait),
    .local_read_req    (local_read_req),
    .local_address     (local_address),
    .imem_filladdr     (imem_filladdr),
    .imem_filldata     (imem_filldata),
    .imem_fillwe       (imem_fillwe),
    .dmem_filladdr     (dmem_filladdr),
    .dmem_filldata     (dmem_filldata),
    .dmem_fillwe       (dmem_fillwe)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic bus_wait(input logic is_data);
    return is_data ? dbus_wait : ibus_wait;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic iline_check(input string name, input iline_t exp, input iline_t act);
    if (exp !== act)
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic dline_check(input string name, input dline_t exp, input dline_t act);
    if (exp !== act)
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic addr_check(input string name, input addr_t exp, input addr_t act);
    if (exp !== act)
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic count_check(input string name, input int exp, input int act);
    if (exp != act)
      stop_on_error($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic add_test(input string name, input int src, input addr_t addr,
                          input logic [31:0] pf, input int lines);
    t_name[t_count]  = name;
    t_src[t_count]   = src;
    t_addr[t_count]  = addr;
    t_pf[t_count]    = pf;
    t_lines[t_count] = lines;
    t_count++;
  endtask

  // DDR controller model, in-order returns two to five cycles after accept
  always @(posedge clk133)
  begin : ddr_model
    int    due;
    addr_t wa;
    cycle = cycle + 1;
    if (!rst_n)
      init_cnt = 0;
    else if (!local_init_done)
    begin
      init_cnt = init_cnt + 1;
      if (init_cnt == 4)
        local_init_done <= 1'b1;
    end
    if (local_read_req && local_ready)
    begin
      due = cycle + 2 + int'(rand_bits(2));
      if (pend_due.size() > 0 && due <= pend_due[$])
        due = pend_due[$] + 1;
      pend_addr.push_back(local_address);
      pend_due.push_back(due);
    end
    if (pend_due.size() > 0 && pend_due[0] <= cycle)
    begin
      wa = pend_addr.pop_front();
      due = pend_due.pop_front();
      local_rdata       <= {4{wa}};
      local_rdata_valid <= 1'b1;
    end
    else
      local_rdata_valid <= 1'b0;
    local_ready <= |rand_bits(2);
  end

  // Collect fills, each must land while its own bus is stalled
  always @(posedge clk133)
  begin
    if (rst_n && imem_fillwe)
    begin
      if (!ibus_wait)
        stop_on_error("An imem fill arrived while ibus_wait was low");
      ifill_addr.push_back(imem_filladdr);
      ifill_data.push_back(imem_filldata);
    end
    if (rst_n && dmem_fillwe)
    begin
      if (!dbus_wait)
        stop_on_error("A dmem fill arrived while dbus_wait was low");
      dfill_addr.push_back(dmem_filladdr);
      dfill_data.push_back(dmem_filldata);
    end
  end

  // Wait for the bus to be granted and released, then drop its en
  task automatic serve_bus(input string name, input logic is_data);
    int n;
    n = 0;
    while (bus_wait(is_data) !== 1'b1)
    begin
      @(posedge clk133);
      n++;
      if (n > 100)
        stop_on_error({name, ": the bus wait never rose"});
    end
    n = 0;
    while (bus_wait(is_data) !== 1'b0)
    begin
      @(posedge clk133);
      n++;
      if (n > 2000)
        stop_on_error({name, ": the bus wait never fell"});
    end
    if (is_data)
      dbus_en <= 1'b0;
    else
      ibus_en <= 1'b0;
  endtask

  task automatic run_test(input int idx);
    string  name;
    int     src;
    int     n;
    int     exp_i;
    int     exp_d;
    logic   first_data;
    addr_t  ibase;
    addr_t  dbase;
    addr_t  laddr;
    addr_t  w0;
    addr_t  w1;
    name  = t_name[idx];
    src   = t_src[idx];
    ibase = t_addr[idx] & ~addr_t'(15);
    dbase = ((src == 2) ? t_addr[idx] + 32'h100 : t_addr[idx]) & ~addr_t'(31);
    exp_i = (src != 1) ? 1 : 0;
    exp_d = (src != 0) ? t_lines[idx] : 0;
    ifill_addr.delete();
    ifill_data.delete();
    dfill_addr.delete();
    dfill_data.delete();
    @(posedge clk133);
    if (src != 1)
    begin
      ibus_en      <= 1'b1;
      ibus_address <= t_addr[idx];
    end
    if (src != 0)
    begin
      dbus_en       <= 1'b1;
      dbus_address  <= (src == 2) ? t_addr[idx] + 32'h100 : t_addr[idx];
      dbus_prefetch <= t_pf[idx];
    end
    if (src == 2)
    begin
      // Contention goes to the bus that did not win last time
      first_data = !last_data;
      n = 0;
      while (!ibus_wait && !dbus_wait)
      begin
        @(posedge clk133);
        n++;
        if (n > 100)
          stop_on_error({name, ": neither bus was granted"});
      end
      count_check({name, " grant"}, int'(first_data), int'(dbus_wait));
      serve_bus(name, first_data);
      serve_bus(name, !first_data);
      last_data = !first_data;
    end
    else
    begin
      serve_bus(name, src == 1);
      last_data = (src == 1);
    end
    count_check({name, " ifills"}, exp_i, ifill_addr.size());
    if (exp_i == 1)
    begin
      w0 = ibase >> 4;
      addr_check({name, " iaddr"}, ibase, ifill_addr[0]);
      iline_check({name, " idata"}, {4{w0}}, ifill_data[0]);
    end
    count_check({name, " dfills"}, exp_d, dfill_addr.size());
    for (int k = 0; k < exp_d; k++)
    begin
      laddr = dbase + addr_t'(k << `DLINE_BYTES_LOG2);
      w0 = laddr >> 4;
      w1 = w0 + 32'd1;
      addr_check($sformatf("%s daddr %0d", name, k), laddr, dfill_addr[k]);
      dline_check($sformatf("%s ddata %0d", name, k), {{4{w1}}, {4{w0}}}, dfill_data[k]);
    end
  endtask

  initial
  begin : main
    int n;
    ibus_en           = 1'b0;
    ibus_address      = '0;
    dbus_en           = 1'b0;
    dbus_address      = '0;
    dbus_prefetch     = '0;
    local_ready       = 1'b0;
    local_init_done   = 1'b0;
    local_rdata       = '0;
    local_rdata_valid = 1'b0;
    add_test("ifetch",          0, 32'h0000_1238, 32'h0000_0000, 1);
    add_test("dfill_default",   1, 32'h0000_2014, 32'h0000_0000, 2);
    add_test("stride4_len20",   1, 32'h0000_3040, 32'h0004_0014, 3);
    add_test("stride_capped",   1, 32'h0000_4000, 32'h0010_001f, 8);
    // Stride 65 has nonzero low stride bits as well as bit 22
    add_test("stride_too_wide", 1, 32'h0000_5020, 32'h0041_0004, 2);
    add_test("contend_i_first", 2, 32'h0000_6010, 32'h0000_0000, 2);
    add_test("ifetch_again",    0, 32'h0000_7ffc, 32'h0000_0000, 1);
    add_test("contend_d_first", 2, 32'h0000_8000, 32'h0004_0014, 3);
    n = 0;
    while (!(rst_n && local_init_done))
    begin
      @(posedge clk133);
      n++;
      if (n > 100)
        stop_on_error("The controller never finished initialisation");
    end
    for (int i = 0; i < t_count; i++)
      run_test(i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
mem_hier_pkg.sv
request_decode.sv
dram_sequencer.sv
fill_assembler.sv
mem_hierarchy.sv
tb_clock_gen.sv
tb_mem_hierarchy.sv

//--- Bender.yml
package:
  name: mem_hierarchy

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_hier_pkg.sv
      - request_decode.sv
      - dram_sequencer.sv
      - fill_assembler.sv
      - mem_hierarchy.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_mem_hierarchy.sv
